// File: xbar_pkg.sv
// Shared definitions for the read-only crossbar
// Bus widths, the read response code, the error responder states and
// the address rule used by every decoder
`default_nettype none

package xbar_pkg;

  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned SLV_ID_W = 4;  // ID width on the slave ports
  localparam int unsigned LEN_W    = 4;  // Beats per burst minus one

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_EXOKAY = 2'd1,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  typedef enum logic {
    ERR_IDLE,
    ERR_BURST
  } err_state_e;

  // One address window, end_addr is exclusive
  typedef struct packed {
    logic [7:0]        idx;
    logic [ADDR_W-1:0] start_addr;
    logic [ADDR_W-1:0] end_addr;
  } addr_rule_t;

endpackage

`default_nettype wire

// File: rd_addr_decode.sv
// Read address decoder
// Scans the rule table with the lowest matching rule winning, falls back to
// the default port when enabled and checks the route against the
// connectivity row. Errors select index NumMstPorts
`timescale 1ns/1ps
`default_nettype none

module rd_addr_decode #(
  parameter int unsigned NumMstPorts = 3,
  parameter int unsigned NumRules    = 3,
  localparam int unsigned MstIdxW    = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1,
  localparam int unsigned SelW       = $clog2(NumMstPorts + 1)
) (
  input  logic [xbar_pkg::ADDR_W-1:0]         addr_i,
  input  xbar_pkg::addr_rule_t [NumRules-1:0] rules_i,
  input  logic                                en_default_i,
  input  logic [MstIdxW-1:0]                  default_idx_i,
  input  logic [NumMstPorts-1:0]              conn_row_i,
  output logic [SelW-1:0]                     select_o,
  output logic                                dec_error_o
);

  logic       matched;
  logic       allowed;
  logic [7:0] target;

  always_comb begin
    matched = 1'b0;
    target  = '0;
    for (int unsigned r = 0; r < NumRules; r++) begin
      if (!matched && (addr_i >= rules_i[r].start_addr) &&
          (addr_i < rules_i[r].end_addr)) begin
        matched = 1'b1;
        target  = rules_i[r].idx;
      end
    end
    if (!matched && en_default_i) begin  // Catch-all port
      matched = 1'b1;
      target  = 8'(default_idx_i);
    end

    allowed = 1'b0;
    if (matched && (target < NumMstPorts)) begin
      allowed = conn_row_i[target[MstIdxW-1:0]];
    end
  end

  assign dec_error_o = !allowed;
  assign select_o    = allowed ? SelW'(target) : SelW'(NumMstPorts);

endmodule

`default_nettype wire

// File: rd_demux.sv
// Read demultiplexer for one slave port
// Steers AR to the selected target and returns R from the stored target.
// Reads go to one target at a time, at most MaxTrans outstanding
`timescale 1ns/1ps
`default_nettype none

module rd_demux #(
  parameter int unsigned NumMstPorts = 3,
  parameter int unsigned MaxTrans    = 4,
  localparam int unsigned NumOut     = NumMstPorts + 1,  // Last one is the error responder
  localparam int unsigned SelW       = $clog2(NumOut),
  localparam int unsigned CntW       = $clog2(MaxTrans + 1)
) (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic                                         slv_arvalid_i,
  output logic                                         slv_arready_o,
  input  logic [xbar_pkg::SLV_ID_W-1:0]                slv_arid_i,
  input  logic [xbar_pkg::ADDR_W-1:0]                  slv_araddr_i,
  input  logic [xbar_pkg::LEN_W-1:0]                   slv_arlen_i,
  input  logic [SelW-1:0]                              select_i,
  output logic [NumOut-1:0]                            mst_arvalid_o,
  input  logic [NumOut-1:0]                            mst_arready_i,
  output logic [xbar_pkg::SLV_ID_W-1:0]                mst_arid_o,
  output logic [xbar_pkg::ADDR_W-1:0]                  mst_araddr_o,
  output logic [xbar_pkg::LEN_W-1:0]                   mst_arlen_o,
  input  logic [NumOut-1:0]                            mst_rvalid_i,
  output logic [NumOut-1:0]                            mst_rready_o,
  input  logic [NumOut-1:0][xbar_pkg::SLV_ID_W-1:0]    mst_rid_i,
  input  logic [NumOut-1:0][xbar_pkg::DATA_W-1:0]      mst_rdata_i,
  input  xbar_pkg::resp_e [NumOut-1:0]                 mst_rresp_i,
  input  logic [NumOut-1:0]                            mst_rlast_i,
  output logic                                         slv_rvalid_o,
  input  logic                                         slv_rready_i,
  output logic [xbar_pkg::SLV_ID_W-1:0]                slv_rid_o,
  output logic [xbar_pkg::DATA_W-1:0]                  slv_rdata_o,
  output xbar_pkg::resp_e                              slv_rresp_o,
  output logic                                         slv_rlast_o
);

  logic [CntW-1:0] cnt_q;     // Reads in flight
  logic [SelW-1:0] target_q;  // Target of the reads in flight
  logic            ar_block;
  logic            ar_hs;
  logic            r_done;

  // Hold a new read while another target still owes data, or at the cap
  assign ar_block = ((cnt_q != '0) && (select_i != target_q)) ||
                    (cnt_q == CntW'(MaxTrans));

  always_comb begin
    mst_arvalid_o           = '0;
    mst_arvalid_o[select_i] = slv_arvalid_i && !ar_block;
  end

  assign slv_arready_o = !ar_block && mst_arready_i[select_i];
  assign mst_arid_o    = slv_arid_i;  // Payload goes to every target
  assign mst_araddr_o  = slv_araddr_i;
  assign mst_arlen_o   = slv_arlen_i;

  assign ar_hs  = slv_arvalid_i && slv_arready_o;
  assign r_done = slv_rvalid_o && slv_rready_i && slv_rlast_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q    <= '0;
      target_q <= '0;
    end else begin
      if (ar_hs) begin
        target_q <= select_i;
      end
      case ({ar_hs, r_done})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // None, or one in and one out
      endcase
    end
  end

  // R path follows the stored target only
  assign slv_rvalid_o = mst_rvalid_i[target_q];
  assign slv_rid_o    = mst_rid_i[target_q];
  assign slv_rdata_o  = mst_rdata_i[target_q];
  assign slv_rresp_o  = mst_rresp_i[target_q];
  assign slv_rlast_o  = mst_rlast_i[target_q];

  always_comb begin
    mst_rready_o           = '0;
    mst_rready_o[target_q] = slv_rready_i;
  end

endmodule

`default_nettype wire

// File: rd_err_slv.sv
// Decode error responder
// Takes one read at a time and answers it with len + 1 DECERR beats,
// the first one in the cycle after the AR is accepted
`timescale 1ns/1ps
`default_nettype none

module rd_err_slv (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  input  logic [xbar_pkg::SLV_ID_W-1:0] arid_i,
  input  logic [xbar_pkg::LEN_W-1:0]    arlen_i,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  output logic [xbar_pkg::SLV_ID_W-1:0] rid_o,
  output logic [xbar_pkg::DATA_W-1:0]   rdata_o,
  output xbar_pkg::resp_e               rresp_o,
  output logic                          rlast_o
);

  import xbar_pkg::*;

  err_state_e        state_q;
  logic [LEN_W-1:0]  beats_q;  // Beats left after the current one
  logic [SLV_ID_W-1:0] id_q;

  assign arready_o = (state_q == ERR_IDLE);
  assign rvalid_o  = (state_q == ERR_BURST);
  assign rid_o     = id_q;
  assign rdata_o   = '0;
  assign rresp_o   = RESP_DECERR;
  assign rlast_o   = (beats_q == '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ERR_IDLE;
      beats_q <= '0;
    end else begin
      case (state_q)
        ERR_IDLE: begin
          if (arvalid_i) begin
            state_q <= ERR_BURST;
            beats_q <= arlen_i;
          end
        end
        ERR_BURST: begin
          if (rready_i) begin
            if (beats_q == '0) begin
              state_q <= ERR_IDLE;  // Last beat taken
            end else begin
              beats_q <= beats_q - 1'b1;
            end
          end
        end
        default: state_q <= ERR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (arvalid_i && arready_o) begin
      id_q <= arid_i;
    end
  end

endmodule

`default_nettype wire

// File: rd_mux.sv
// Read multiplexer for one master port
// Round-robin AR arbitration with the grant held until the transfer,
// the slave index is prepended to the ID and R is steered back by it
`timescale 1ns/1ps
`default_nettype none

module rd_mux #(
  parameter int unsigned NumSlvPorts = 2,
  localparam int unsigned SlvIdxW    = (NumSlvPorts > 1) ? $clog2(NumSlvPorts) : 1,
  localparam int unsigned MstIdW     = xbar_pkg::SLV_ID_W + SlvIdxW
) (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic [NumSlvPorts-1:0]                        slv_arvalid_i,
  output logic [NumSlvPorts-1:0]                        slv_arready_o,
  input  logic [NumSlvPorts-1:0][xbar_pkg::SLV_ID_W-1:0] slv_arid_i,
  input  logic [NumSlvPorts-1:0][xbar_pkg::ADDR_W-1:0]  slv_araddr_i,
  input  logic [NumSlvPorts-1:0][xbar_pkg::LEN_W-1:0]   slv_arlen_i,
  output logic                                          mst_arvalid_o,
  input  logic                                          mst_arready_i,
  output logic [MstIdW-1:0]                             mst_arid_o,
  output logic [xbar_pkg::ADDR_W-1:0]                   mst_araddr_o,
  output logic [xbar_pkg::LEN_W-1:0]                    mst_arlen_o,
  input  logic                                          mst_rvalid_i,
  output logic                                          mst_rready_o,
  input  logic [MstIdW-1:0]                             mst_rid_i,
  input  logic [xbar_pkg::DATA_W-1:0]                   mst_rdata_i,
  input  xbar_pkg::resp_e                               mst_rresp_i,
  input  logic                                          mst_rlast_i,
  output logic [NumSlvPorts-1:0]                        slv_rvalid_o,
  input  logic [NumSlvPorts-1:0]                        slv_rready_i,
  output logic [xbar_pkg::SLV_ID_W-1:0]                 slv_rid_o,
  output logic [xbar_pkg::DATA_W-1:0]                   slv_rdata_o,
  output xbar_pkg::resp_e                               slv_rresp_o,
  output logic                                          slv_rlast_o
);

  import xbar_pkg::*;

  logic [SlvIdxW-1:0] rr_q;        // Input with the highest priority
  logic               lock_q;      // Granted AR still waiting for ready
  logic [SlvIdxW-1:0] lock_idx_q;
  logic [SlvIdxW-1:0] gnt_idx;
  logic               gnt_valid;
  logic [SlvIdxW-1:0] r_idx;

  always_comb begin
    int unsigned cand;
    gnt_valid = 1'b0;
    gnt_idx   = rr_q;
    for (int unsigned k = 0; k < NumSlvPorts; k++) begin
      cand = (int'(rr_q) + k) % NumSlvPorts;
      if (!gnt_valid && slv_arvalid_i[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = SlvIdxW'(cand);
      end
    end
    if (lock_q) begin
      gnt_idx   = lock_idx_q;
      gnt_valid = slv_arvalid_i[lock_idx_q];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= mst_arvalid_o && !mst_arready_i;
      lock_idx_q <= gnt_idx;
      if (mst_arvalid_o && mst_arready_i) begin  // Winner drops to lowest priority
        rr_q <= (gnt_idx == SlvIdxW'(NumSlvPorts - 1)) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

  assign mst_arvalid_o = gnt_valid;
  assign mst_arid_o    = {gnt_idx, slv_arid_i[gnt_idx]};
  assign mst_araddr_o  = slv_araddr_i[gnt_idx];
  assign mst_arlen_o   = slv_arlen_i[gnt_idx];

  always_comb begin
    slv_arready_o          = '0;
    slv_arready_o[gnt_idx] = gnt_valid && mst_arready_i;
  end

  // Top ID bits name the slave input that owns the beat
  assign r_idx = mst_rid_i[MstIdW-1 -: SlvIdxW];

  always_comb begin
    slv_rvalid_o        = '0;
    slv_rvalid_o[r_idx] = mst_rvalid_i;
  end

  assign mst_rready_o = slv_rready_i[r_idx];
  assign slv_rid_o    = mst_rid_i[SLV_ID_W-1:0];
  assign slv_rdata_o  = mst_rdata_i;
  assign slv_rresp_o  = mst_rresp_i;
  assign slv_rlast_o  = mst_rlast_i;

endmodule

`default_nettype wire

// File: rd_xbar.sv
// Read-only address-routed crossbar
// Per slave port a decoder, a demux and an error responder, per master
// port a round-robin mux. Forbidden pairs are left unwired
`timescale 1ns/1ps
`default_nettype none

module rd_xbar #(
  parameter int unsigned NumSlvPorts = 2,
  parameter int unsigned NumMstPorts = 3,
  parameter int unsigned NumRules    = 3,
  parameter int unsigned MaxTrans    = 4,
  parameter logic [NumSlvPorts-1:0][NumMstPorts-1:0] Connectivity = '1,
  localparam int unsigned MstIdxW = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1,
  localparam int unsigned SlvIdxW = (NumSlvPorts > 1) ? $clog2(NumSlvPorts) : 1,
  localparam int unsigned MstIdW  = xbar_pkg::SLV_ID_W + SlvIdxW
) (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  input  xbar_pkg::addr_rule_t [NumRules-1:0]            rules_i,
  input  logic [NumSlvPorts-1:0]                         en_default_i,
  input  logic [NumSlvPorts-1:0][MstIdxW-1:0]            default_idx_i,
  input  logic [NumSlvPorts-1:0]                         slv_arvalid_i,
  output logic [NumSlvPorts-1:0]                         slv_arready_o,
  input  logic [NumSlvPorts-1:0][xbar_pkg::SLV_ID_W-1:0] slv_arid_i,
  input  logic [NumSlvPorts-1:0][xbar_pkg::ADDR_W-1:0]   slv_araddr_i,
  input  logic [NumSlvPorts-1:0][xbar_pkg::LEN_W-1:0]    slv_arlen_i,
  output logic [NumSlvPorts-1:0]                         slv_rvalid_o,
  input  logic [NumSlvPorts-1:0]                         slv_rready_i,
  output logic [NumSlvPorts-1:0][xbar_pkg::SLV_ID_W-1:0] slv_rid_o,
  output logic [NumSlvPorts-1:0][xbar_pkg::DATA_W-1:0]   slv_rdata_o,
  output xbar_pkg::resp_e [NumSlvPorts-1:0]              slv_rresp_o,
  output logic [NumSlvPorts-1:0]                         slv_rlast_o,
  output logic [NumMstPorts-1:0]                         mst_arvalid_o,
  input  logic [NumMstPorts-1:0]                         mst_arready_i,
  output logic [NumMstPorts-1:0][MstIdW-1:0]             mst_arid_o,
  output logic [NumMstPorts-1:0][xbar_pkg::ADDR_W-1:0]   mst_araddr_o,
  output logic [NumMstPorts-1:0][xbar_pkg::LEN_W-1:0]    mst_arlen_o,
  input  logic [NumMstPorts-1:0]                         mst_rvalid_i,
  output logic [NumMstPorts-1:0]                         mst_rready_o,
  input  logic [NumMstPorts-1:0][MstIdW-1:0]             mst_rid_i,
  input  logic [NumMstPorts-1:0][xbar_pkg::DATA_W-1:0]   mst_rdata_i,
  input  xbar_pkg::resp_e [NumMstPorts-1:0]              mst_rresp_i,
  input  logic [NumMstPorts-1:0]                         mst_rlast_i
);

  import xbar_pkg::*;

  localparam int unsigned NumOut = NumMstPorts + 1;
  localparam int unsigned SelW   = $clog2(NumOut);

  // Demux side, index NumMstPorts is the error responder
  logic [NumSlvPorts-1:0][SelW-1:0]                 sel;
  logic [NumSlvPorts-1:0][NumOut-1:0]               dmx_arvalid, dmx_arready;
  logic [NumSlvPorts-1:0][SLV_ID_W-1:0]             dmx_arid;
  logic [NumSlvPorts-1:0][ADDR_W-1:0]               dmx_araddr;
  logic [NumSlvPorts-1:0][LEN_W-1:0]                dmx_arlen;
  logic [NumSlvPorts-1:0][NumOut-1:0]               dmx_rvalid, dmx_rready, dmx_rlast;
  logic [NumSlvPorts-1:0][NumOut-1:0][SLV_ID_W-1:0] dmx_rid;
  logic [NumSlvPorts-1:0][NumOut-1:0][DATA_W-1:0]   dmx_rdata;
  resp_e [NumSlvPorts-1:0][NumOut-1:0]              dmx_rresp;

  // Mux side
  logic [NumMstPorts-1:0][NumSlvPorts-1:0]               mux_arvalid, mux_arready;
  logic [NumMstPorts-1:0][NumSlvPorts-1:0][SLV_ID_W-1:0] mux_arid;
  logic [NumMstPorts-1:0][NumSlvPorts-1:0][ADDR_W-1:0]   mux_araddr;
  logic [NumMstPorts-1:0][NumSlvPorts-1:0][LEN_W-1:0]    mux_arlen;
  logic [NumMstPorts-1:0][NumSlvPorts-1:0]               mux_rvalid, mux_rready;
  logic [NumMstPorts-1:0][SLV_ID_W-1:0]                  mux_rid;
  logic [NumMstPorts-1:0][DATA_W-1:0]                    mux_rdata;
  resp_e [NumMstPorts-1:0]                               mux_rresp;
  logic [NumMstPorts-1:0]                                mux_rlast;

  for (genvar i = 0; i < NumSlvPorts; i++) begin : gen_slv
    rd_addr_decode #(.NumMstPorts(NumMstPorts), .NumRules(NumRules)) i_decode (
      .addr_i(slv_araddr_i[i]), .rules_i(rules_i), .en_default_i(en_default_i[i]),
      .default_idx_i(default_idx_i[i]), .conn_row_i(Connectivity[i]),
      .select_o(sel[i]), .dec_error_o()
    );

    rd_demux #(.NumMstPorts(NumMstPorts), .MaxTrans(MaxTrans)) i_demux (
      .clk_i, .arst_n_i,
      .slv_arvalid_i(slv_arvalid_i[i]), .slv_arready_o(slv_arready_o[i]),
      .slv_arid_i(slv_arid_i[i]), .slv_araddr_i(slv_araddr_i[i]),
      .slv_arlen_i(slv_arlen_i[i]), .select_i(sel[i]),
      .mst_arvalid_o(dmx_arvalid[i]), .mst_arready_i(dmx_arready[i]),
      .mst_arid_o(dmx_arid[i]), .mst_araddr_o(dmx_araddr[i]), .mst_arlen_o(dmx_arlen[i]),
      .mst_rvalid_i(dmx_rvalid[i]), .mst_rready_o(dmx_rready[i]), .mst_rid_i(dmx_rid[i]),
      .mst_rdata_i(dmx_rdata[i]), .mst_rresp_i(dmx_rresp[i]), .mst_rlast_i(dmx_rlast[i]),
      .slv_rvalid_o(slv_rvalid_o[i]), .slv_rready_i(slv_rready_i[i]),
      .slv_rid_o(slv_rid_o[i]), .slv_rdata_o(slv_rdata_o[i]),
      .slv_rresp_o(slv_rresp_o[i]), .slv_rlast_o(slv_rlast_o[i])
    );

    rd_err_slv i_err_slv (
      .clk_i, .arst_n_i,
      .arvalid_i(dmx_arvalid[i][NumMstPorts]), .arready_o(dmx_arready[i][NumMstPorts]),
      .arid_i(dmx_arid[i]), .arlen_i(dmx_arlen[i]),
      .rvalid_o(dmx_rvalid[i][NumMstPorts]), .rready_i(dmx_rready[i][NumMstPorts]),
      .rid_o(dmx_rid[i][NumMstPorts]), .rdata_o(dmx_rdata[i][NumMstPorts]),
      .rresp_o(dmx_rresp[i][NumMstPorts]), .rlast_o(dmx_rlast[i][NumMstPorts])
    );

    for (genvar j = 0; j < NumMstPorts; j++) begin : gen_cross
      assign mux_arid[j][i]   = dmx_arid[i];  // Payload is shared, valid gates it
      assign mux_araddr[j][i] = dmx_araddr[i];
      assign mux_arlen[j][i]  = dmx_arlen[i];
      assign dmx_rid[i][j]    = mux_rid[j];
      assign dmx_rdata[i][j]  = mux_rdata[j];
      assign dmx_rresp[i][j]  = mux_rresp[j];
      assign dmx_rlast[i][j]  = mux_rlast[j];
      if (Connectivity[i][j]) begin : gen_link
        assign mux_arvalid[j][i] = dmx_arvalid[i][j];
        assign dmx_arready[i][j] = mux_arready[j][i];
        assign dmx_rvalid[i][j]  = mux_rvalid[j][i];
        assign mux_rready[j][i]  = dmx_rready[i][j];
      end else begin : gen_no_link  // Decoder never selects this pair
        assign mux_arvalid[j][i] = 1'b0;
        assign dmx_arready[i][j] = 1'b0;
        assign dmx_rvalid[i][j]  = 1'b0;
        assign mux_rready[j][i]  = 1'b0;
      end
    end
  end

  for (genvar j = 0; j < NumMstPorts; j++) begin : gen_mst
    rd_mux #(.NumSlvPorts(NumSlvPorts)) i_mux (
      .clk_i, .arst_n_i,
      .slv_arvalid_i(mux_arvalid[j]), .slv_arready_o(mux_arready[j]),
      .slv_arid_i(mux_arid[j]), .slv_araddr_i(mux_araddr[j]), .slv_arlen_i(mux_arlen[j]),
      .mst_arvalid_o(mst_arvalid_o[j]), .mst_arready_i(mst_arready_i[j]),
      .mst_arid_o(mst_arid_o[j]), .mst_araddr_o(mst_araddr_o[j]),
      .mst_arlen_o(mst_arlen_o[j]),
      .mst_rvalid_i(mst_rvalid_i[j]), .mst_rready_o(mst_rready_o[j]),
      .mst_rid_i(mst_rid_i[j]), .mst_rdata_i(mst_rdata_i[j]),
      .mst_rresp_i(mst_rresp_i[j]), .mst_rlast_i(mst_rlast_i[j]),
      .slv_rvalid_o(mux_rvalid[j]), .slv_rready_i(mux_rready[j]),
      .slv_rid_o(mux_rid[j]), .slv_rdata_o(mux_rdata[j]),
      .slv_rresp_o(mux_rresp[j]), .slv_rlast_o(mux_rlast[j])
    );
  end

endmodule

`default_nettype wire

// File: tb_rd_xbar.sv
// Testbench for the read-only crossbar
// Applies a table of reads to the slave ports, models a memory on each
// master port and checks every R beat against the routing rules
`timescale 1ns/1ps
`default_nettype none

module tb_rd_xbar;

  import xbar_pkg::*;

  localparam int unsigned NumSlvPorts = 2;
  localparam int unsigned NumMstPorts = 3;
  localparam int unsigned NumRules    = 3;
  localparam int unsigned MaxTrans    = 4;
  localparam int unsigned MstIdxW     = 2;
  localparam int unsigned MstIdW      = SLV_ID_W + 1;
  // Slave 1 may not reach master 2
  localparam logic [NumSlvPorts-1:0][NumMstPorts-1:0] Connectivity = {3'b011, 3'b111};

  typedef struct packed {
    logic [7:0]          slv;
    logic [SLV_ID_W-1:0] id;
    logic [ADDR_W-1:0]   addr;
    logic [LEN_W-1:0]    len;
    logic                en_def;
    logic [MstIdxW-1:0]  def_idx;
    logic                dec_err;
    logic [7:0]          mst;
  } rd_t;

  typedef struct packed {
    logic [MstIdW-1:0] id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } mem_t;

  logic clk_i;
  logic arst_n_i;
  addr_rule_t [NumRules-1:0]                 rules_i;
  logic [NumSlvPorts-1:0]                    en_default_i;
  logic [NumSlvPorts-1:0][MstIdxW-1:0]       default_idx_i;
  logic [NumSlvPorts-1:0]                    slv_arvalid_i, slv_arready_o;
  logic [NumSlvPorts-1:0][SLV_ID_W-1:0]      slv_arid_i, slv_rid_o;
  logic [NumSlvPorts-1:0][ADDR_W-1:0]        slv_araddr_i;
  logic [NumSlvPorts-1:0][LEN_W-1:0]         slv_arlen_i;
  logic [NumSlvPorts-1:0]                    slv_rvalid_o, slv_rready_i, slv_rlast_o;
  logic [NumSlvPorts-1:0][DATA_W-1:0]        slv_rdata_o;
  resp_e [NumSlvPorts-1:0]                   slv_rresp_o;
  logic [NumMstPorts-1:0]                    mst_arvalid_o, mst_arready_i;
  logic [NumMstPorts-1:0][MstIdW-1:0]        mst_arid_o, mst_rid_i;
  logic [NumMstPorts-1:0][ADDR_W-1:0]        mst_araddr_o;
  logic [NumMstPorts-1:0][LEN_W-1:0]         mst_arlen_o;
  logic [NumMstPorts-1:0]                    mst_rvalid_i, mst_rready_o, mst_rlast_i;
  logic [NumMstPorts-1:0][DATA_W-1:0]        mst_rdata_i;
  resp_e [NumMstPorts-1:0]                   mst_rresp_i;

  rd_t   table_q[$];
  string name_q[$];
  rd_t   ar_q [NumSlvPorts][$];   // Reads still to be issued per slave port
  rd_t   exp_q [NumSlvPorts][$];  // Reads still owing R beats in request order
  rd_t   ar_exp[$];               // ARs that some master port must still see
  mem_t  mem_q [NumMstPorts][$];
  int    beat_cnt [NumSlvPorts];
  int    mem_beat [NumMstPorts];
  int    errors, total_beats, cycles, cycle_limit;
  string cur_name;
  int unsigned rand_state = 81;

  rd_xbar #(
    .NumSlvPorts(NumSlvPorts), .NumMstPorts(NumMstPorts), .NumRules(NumRules),
    .MaxTrans(MaxTrans), .Connectivity(Connectivity)
  ) uut (
    .clk_i, .arst_n_i, .rules_i, .en_default_i, .default_idx_i,
    .slv_arvalid_i, .slv_arready_o, .slv_arid_i, .slv_araddr_i, .slv_arlen_i,
    .slv_rvalid_o, .slv_rready_i, .slv_rid_o, .slv_rdata_o, .slv_rresp_o, .slv_rlast_o,
    .mst_arvalid_o, .mst_arready_i, .mst_arid_o, .mst_araddr_o, .mst_arlen_o,
    .mst_rvalid_i, .mst_rready_o, .mst_rid_i, .mst_rdata_i, .mst_rresp_i, .mst_rlast_i
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic int unsigned next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state >> 16;
  endfunction

  // Master index in the top byte and the address plus beat number below it
  function automatic logic [DATA_W-1:0] expect_data(input int mst, input logic [ADDR_W-1:0] addr,
                                                    input int beat);
    return {8'(mst), 24'(addr + 32'(beat))};
  endfunction

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s data: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input resp_e exp, input resp_e act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s resp: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_id(input string name, input logic [SLV_ID_W-1:0] exp,
                          input logic [SLV_ID_W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s id: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_beats(input string name, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("CHECK FAILED %s beats: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // mst < 0 means the read must end in a decode error
  task automatic add_row(input string name, input int slv, input int id, input int addr,
                         input int len, input bit en_def, input int def_idx, input int mst);
    rd_t e;
    e.slv     = 8'(slv);
    e.id      = SLV_ID_W'(id);
    e.addr    = ADDR_W'(addr);
    e.len     = LEN_W'(len);
    e.en_def  = en_def;
    e.def_idx = MstIdxW'(def_idx);
    e.dec_err = (mst < 0);
    e.mst     = (mst < 0) ? 8'd0 : 8'(mst);
    table_q.push_back(e);
    name_q.push_back(name);
    total_beats += len + 1;
  endtask

  task automatic take_beat(input int s);
    rd_t   e;
    resp_e exp_r;
    if (exp_q[s].size() == 0) begin
      errors++;
      $display("ERROR: R beat on slave port %0d while no read is pending", s);
      return;
    end
    e     = exp_q[s][0];
    exp_r = e.dec_err ? RESP_DECERR : RESP_OKAY;
    check_id(cur_name, e.id, slv_rid_o[s]);
    check_data(cur_name, e.dec_err ? '0 : expect_data(e.mst, e.addr, beat_cnt[s]),
               slv_rdata_o[s]);
    check_resp(cur_name, exp_r, slv_rresp_o[s]);
    beat_cnt[s]++;
    if (slv_rlast_o[s]) begin
      check_beats(cur_name, int'(e.len) + 1, beat_cnt[s]);
      void'(exp_q[s].pop_front());
      beat_cnt[s] = 0;
    end
  endtask

  // The slave index above the original ID must match the issuing port
  task automatic accept_ar(input int m);
    logic [MstIdW-1:0] id;
    int                hit;
    mem_t              req;
    id  = mst_arid_o[m];
    hit = -1;
    foreach (ar_exp[k]) begin
      if (hit < 0 && ar_exp[k].mst == m && int'(ar_exp[k].slv) == int'(id >> SLV_ID_W) &&
          ar_exp[k].id == id[SLV_ID_W-1:0] && ar_exp[k].addr == mst_araddr_o[m] &&
          ar_exp[k].len == mst_arlen_o[m]) begin
        hit = k;
      end
    end
    if (hit < 0) begin
      errors++;
      $display("ERROR: unexpected AR on master port %0d, id %h addr %h", m, id, mst_araddr_o[m]);
    end else begin
      ar_exp.delete(hit);
    end
    req.id   = id;
    req.addr = mst_araddr_o[m];
    req.len  = mst_arlen_o[m];
    mem_q[m].push_back(req);
  endtask

  function automatic bit reads_pending();
    bit busy;
    busy = (ar_exp.size() != 0);
    for (int s = 0; s < NumSlvPorts; s++) begin
      busy |= (ar_q[s].size() != 0) || (exp_q[s].size() != 0);
    end
    for (int m = 0; m < NumMstPorts; m++) begin
      busy |= (mem_q[m].size() != 0);
    end
    return busy;
  endfunction

  // Handshakes sampled at the rising edge before the DUT updates
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      for (int s = 0; s < NumSlvPorts; s++) begin
        if (slv_arvalid_i[s] && slv_arready_o[s]) void'(ar_q[s].pop_front());
        if (slv_rvalid_o[s] && slv_rready_i[s]) take_beat(s);
      end
      for (int m = 0; m < NumMstPorts; m++) begin
        if (mst_arvalid_o[m] && mst_arready_i[m]) accept_ar(m);
        if (mst_rvalid_i[m] && mst_rready_o[m]) begin
          mem_beat[m]++;
          if (mst_rlast_i[m]) begin
            void'(mem_q[m].pop_front());
            mem_beat[m] = 0;
          end
        end
      end
    end
  end

  always @(negedge clk_i) begin
    for (int s = 0; s < NumSlvPorts; s++) begin
      slv_arvalid_i[s] = (ar_q[s].size() != 0);
      if (ar_q[s].size() != 0) begin
        slv_arid_i[s]    = ar_q[s][0].id;
        slv_araddr_i[s]  = ar_q[s][0].addr;
        slv_arlen_i[s]   = ar_q[s][0].len;
        en_default_i[s]  = ar_q[s][0].en_def;
        default_idx_i[s] = ar_q[s][0].def_idx;
      end
      slv_rready_i[s] = (next_rand() % 4) != 0;  // Random stalls
    end
    for (int m = 0; m < NumMstPorts; m++) begin
      mst_arready_i[m] = (next_rand() % 3) != 0;
      mst_rvalid_i[m]  = (mem_q[m].size() != 0);
      mst_rlast_i[m]   = 1'b0;
      if (mem_q[m].size() != 0) begin
        mst_rid_i[m]   = mem_q[m][0].id;  // Extended ID echoed back
        mst_rdata_i[m] = {8'(m), 24'(mem_q[m][0].addr + 32'(mem_beat[m]))};
        mst_rresp_i[m] = RESP_OKAY;
        mst_rlast_i[m] = (mem_beat[m] == int'(mem_q[m][0].len));
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: reads still pending after %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    int row;
    int err_start;
    int tests;
    int failed;
    arst_n_i = 1'b0;
    {slv_arvalid_i, slv_rready_i, en_default_i, default_idx_i} = '0;
    {slv_arid_i, slv_araddr_i, slv_arlen_i} = '0;
    {mst_arready_i, mst_rvalid_i, mst_rlast_i, mst_rid_i, mst_rdata_i} = '0;
    for (int m = 0; m < NumMstPorts; m++) begin
      mst_rresp_i[m] = RESP_OKAY;
    end
    for (int r = 0; r < NumRules; r++) begin
      rules_i[r].idx        = 8'(r);
      rules_i[r].start_addr = 32'(r * 32'h1000);
      rules_i[r].end_addr   = 32'((r + 1) * 32'h1000);  // Exclusive end
    end
    //       name           slv id    addr    len def idx mst
    add_row("route_m0",     0, 1,  'h0100, 3, 0, 0, 0);
    add_row("route_m1",     0, 2,  'h1200, 0, 0, 0, 1);
    add_row("route_m2",     0, 3,  'h2300, 2, 0, 0, 2);
    add_row("decode_error", 0, 5,  'h8000, 2, 0, 0, -1);
    add_row("default_port", 0, 6,  'h8000, 1, 1, 1, 1);
    add_row("connectivity", 1, 7,  'h2040, 1, 0, 0, -1);
    add_row("connectivity", 0, 7,  'h2040, 1, 0, 0, 2);
    add_row("concurrent",   0, 9,  'h0400, 2, 0, 0, 0);
    add_row("concurrent",   1, 9,  'h0800, 3, 0, 0, 0);
    add_row("backpressure", 1, 10, 'h0010, 3, 0, 0, 0);
    add_row("backpressure", 1, 11, 'h1010, 2, 0, 0, 1);
    add_row("backpressure", 1, 12, 'h0020, 0, 0, 0, 0);
    add_row("backpressure", 1, 13, 'h1ff0, 7, 0, 0, 1);
    cycle_limit = 40 * total_beats;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    row      = 0;
    tests    = 0;
    failed   = 0;
    while (row < table_q.size()) begin
      cur_name  = name_q[row];
      err_start = errors;
      @(posedge clk_i);
      while (row < table_q.size() && name_q[row] == cur_name) begin  // Rows of one test issue together
        ar_q[table_q[row].slv].push_back(table_q[row]);
        exp_q[table_q[row].slv].push_back(table_q[row]);
        if (!table_q[row].dec_err) ar_exp.push_back(table_q[row]);
        row++;
      end
      do @(negedge clk_i); while (reads_pending());
      tests++;
      if (errors == err_start) begin
        $display("test %s passed", cur_name);
      end else begin
        failed++;
        $display("test %s failed with %0d errors", cur_name, errors - err_start);
      end
    end
    $display("Summary: %0d tests, %0d failed, %0d check errors", tests, failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
xbar_pkg.sv
rd_addr_decode.sv
rd_demux.sv
rd_err_slv.sv
rd_mux.sv
rd_xbar.sv
tb_rd_xbar.sv

// File: Bender.yml
package:
  name: rd_xbar

sources:
  - xbar_pkg.sv
  - rd_addr_decode.sv
  - rd_demux.sv
  - rd_err_slv.sv
  - rd_mux.sv
  - rd_xbar.sv
  - target: test
    files:
      - tb_rd_xbar.sv
